// ==== common/igr_pkg.sv ====
// ==========================================================
// Ingress front end shared definitions
// Beat and descriptor structs, FSM state encodings and
// the sizing constants used by the port receivers and merge
// ==========================================================

`default_nettype none

package igr_pkg;

  // ==========================================================
  // Sizing
  // ==========================================================

  // Data word on the receive beat stream
  localparam int DATA_W = 32;

  // Word count field of a descriptor
  localparam int LEN_W = 8;

  // Length saturates here, anything longer is flagged
  localparam logic [LEN_W-1:0] MAX_WORDS = 8'd255;

  // Ports feeding the merge
  localparam int NUM_PORTS = 2;

  // Port field and round-robin pointer width
  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  // Per-port drop counter, wraps
  localparam int CNT_W = 16;

  // ==========================================================
  // Structs
  // ==========================================================

  // One receive beat, no back-pressure on this stream
  typedef struct packed {
    logic              valid;
    logic              sop;
    logic              eop;
    logic [DATA_W-1:0] data;
  } cdi_beat_t;

  // Condensed frame summary handed to the merge
  // Port is filled in by the merge, zero out of a receiver
  typedef struct packed {
    logic [PORT_W-1:0] port;
    logic              err;
    logic [LEN_W-1:0]  length;
    logic [DATA_W-1:0] head;
    logic [DATA_W-1:0] checksum;
  } igr_desc_t;

  // ==========================================================
  // FSM states
  // ==========================================================

  // Frame assembly in a port receiver
  typedef enum logic {
    RX_IDLE,
    RX_FRAME
  } rx_state_e;

  // Downstream four-phase handshake in the merge
  typedef enum logic [1:0] {
    MG_IDLE,
    MG_REQ,
    MG_RELEASE
  } merge_state_e;

endpackage

`default_nettype wire

// ==== filelist.f ====
common/igr_pkg.sv
hw/igr_port_rx/igr_port_rx.sv
hw/igr_merge/igr_merge.sv
hw/igr_top.sv
tests/igr_properties.sv
tests/igr_tb.sv

// ==== hw/igr_merge/igr_merge.sv ====
// ==========================================================
// Ingress merge
// Round-robin pick between the two port receivers, tags the
// descriptor with its source port and presents it on a
// four-phase req/ack handshake towards downstream
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module igr_merge (
  input  wire                        ingress_clock,
  input  wire                        rst_n,
  input  wire                        desc_valid0,
  input  igr_pkg::igr_desc_t         desc0,
  input  wire                        desc_valid1,
  input  igr_pkg::igr_desc_t         desc1,
  input  wire                        ack,
  output logic                       take0,
  output logic                       take1,
  output logic                       req,
  output igr_pkg::igr_desc_t         out_desc
);

  // ==========================================================
  // Arbitration
  // ==========================================================

  igr_pkg::merge_state_e           state;

  // Last port served, loser of the next tie
  logic [igr_pkg::PORT_W-1:0]      rr_last;

  logic                            any_valid;
  logic [igr_pkg::PORT_W-1:0]      sel;
  logic                            pick;
  igr_pkg::igr_desc_t              pick_desc;

  assign any_valid = desc_valid0 || desc_valid1;

  always_comb begin
    // Tie goes to the port not served last
    if (desc_valid0 && desc_valid1) begin
      sel = ~rr_last;
    end else if (desc_valid1) begin
      sel = igr_pkg::PORT_W'(1);
    end else begin
      sel = igr_pkg::PORT_W'(0);
    end
  end

  // Grant only while the handshake is idle
  assign pick = (state == igr_pkg::MG_IDLE) && any_valid;

  // One-cycle take, the receiver clears its slot on the next edge
  assign take0 = pick && (sel == igr_pkg::PORT_W'(0));
  assign take1 = pick && (sel == igr_pkg::PORT_W'(1));

  always_comb begin
    pick_desc      = (sel == igr_pkg::PORT_W'(0)) ? desc0 : desc1;
    // Source port tag
    pick_desc.port = sel;
  end

  // ==========================================================
  // Four-phase handshake
  // ==========================================================

  // req follows the state directly, rises the edge after take
  assign req = (state == igr_pkg::MG_REQ);

  always_ff @(posedge ingress_clock or negedge rst_n) begin
    if (!rst_n) begin
      state   <= igr_pkg::MG_IDLE;
      // Port 0 wins the first tie
      rr_last <= igr_pkg::PORT_W'(igr_pkg::NUM_PORTS - 1);
    end else begin
      case (state)
        igr_pkg::MG_IDLE: begin
          if (pick) begin
            rr_last <= sel;
            state   <= igr_pkg::MG_REQ;
          end
        end
        igr_pkg::MG_REQ: begin
          // Downstream took it, drop req
          if (ack) begin
            state <= igr_pkg::MG_RELEASE;
          end
        end
        igr_pkg::MG_RELEASE: begin
          // No new req until ack is back low
          if (!ack) begin
            state <= igr_pkg::MG_IDLE;
          end
        end
        default: begin
          state <= igr_pkg::MG_IDLE;
        end
      endcase
    end
  end

  // Output payload, held from req rise until ack falls
  always_ff @(posedge ingress_clock) begin
    if (pick) begin
      out_desc <= pick_desc;
    end
  end

endmodule

`default_nettype wire

// ==== hw/igr_port_rx/igr_port_rx.sv ====
// ==========================================================
// Ingress port receiver
// Condenses each frame of the beat stream into a descriptor
// (head word, word count, XOR checksum, error flag), holds
// one finished descriptor for the merge and counts frames
// that finish while that slot is still occupied
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module igr_port_rx (
  input  wire                           ingress_clock,
  input  wire                           rst_n,
  input  igr_pkg::cdi_beat_t            beat,
  input  wire                           take,
  output logic                          desc_valid,
  output igr_pkg::igr_desc_t            desc,
  output logic [igr_pkg::CNT_W-1:0]     drop_count
);

  // ==========================================================
  // Frame assembly
  // ==========================================================

  igr_pkg::rx_state_e               state;
  igr_pkg::rx_state_e               nxt_state;

  // Running frame summary
  logic [igr_pkg::DATA_W-1:0]       acc_head;
  logic [igr_pkg::LEN_W-1:0]        acc_len;
  logic [igr_pkg::DATA_W-1:0]       acc_csum;
  logic                             acc_err;

  logic [igr_pkg::DATA_W-1:0]       nxt_head;
  logic [igr_pkg::LEN_W-1:0]        nxt_len;
  logic [igr_pkg::DATA_W-1:0]       nxt_csum;
  logic                             nxt_err;
  logic                             nxt_done;

  // Accumulators hold a complete frame for one cycle
  logic                             done_q;

  // Slot takes the finished frame this cycle
  logic                             slot_load;

  always_comb begin
    nxt_state = state;
    nxt_head  = acc_head;
    nxt_len   = acc_len;
    nxt_csum  = acc_csum;
    nxt_err   = acc_err;
    nxt_done  = 1'b0;

    if (beat.valid) begin
      if (beat.sop) begin
        // New frame, a sop inside a frame abandons the old one
        nxt_head  = beat.data;
        nxt_len   = igr_pkg::LEN_W'(1);
        nxt_csum  = beat.data;
        nxt_err   = (state == igr_pkg::RX_FRAME);
        // sop together with eop is a one-word frame
        nxt_done  = beat.eop;
        nxt_state = beat.eop ? igr_pkg::RX_IDLE : igr_pkg::RX_FRAME;
      end else if (state == igr_pkg::RX_FRAME) begin
        // Count saturates, words beyond it still enter the checksum
        if (acc_len == igr_pkg::MAX_WORDS) begin
          nxt_err = 1'b1;
        end else begin
          nxt_len = acc_len + igr_pkg::LEN_W'(1);
        end
        nxt_csum = acc_csum ^ beat.data;
        if (beat.eop) begin
          nxt_done  = 1'b1;
          nxt_state = igr_pkg::RX_IDLE;
        end
      end
      // Valid beat outside a frame without sop is ignored
    end
  end

  // Control state
  always_ff @(posedge ingress_clock or negedge rst_n) begin
    if (!rst_n) begin
      state  <= igr_pkg::RX_IDLE;
      done_q <= 1'b0;
    end else begin
      state  <= nxt_state;
      done_q <= nxt_done;
    end
  end

  // Accumulator payload
  always_ff @(posedge ingress_clock) begin
    acc_head <= nxt_head;
    acc_len  <= nxt_len;
    acc_csum <= nxt_csum;
    acc_err  <= nxt_err;
  end

  // ==========================================================
  // Descriptor slot and drop counter
  // ==========================================================

  // Free slot, or one emptied by take in this same cycle
  assign slot_load = done_q && (!desc_valid || take);

  always_ff @(posedge ingress_clock or negedge rst_n) begin
    if (!rst_n) begin
      desc_valid <= 1'b0;
      drop_count <= '0;
    end else begin
      if (done_q) begin
        if (slot_load) begin
          desc_valid <= 1'b1;
        end else begin
          // Slot still full, frame lost
          drop_count <= drop_count + igr_pkg::CNT_W'(1);
        end
      end else if (take) begin
        desc_valid <= 1'b0;
      end
    end
  end

  // Port field stays zero, the merge tags it
  always_ff @(posedge ingress_clock) begin
    if (slot_load) begin
      desc.port     <= '0;
      desc.err      <= acc_err;
      desc.length   <= acc_len;
      desc.head     <= acc_head;
      desc.checksum <= acc_csum;
    end
  end

endmodule

`default_nettype wire

// ==== hw/igr_top.sv ====
// ==========================================================
// Ingress front end top level
// Two port receivers feeding one round-robin merge with a
// four-phase downstream handshake
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module igr_top (
  input  wire                          ingress_clock,
  input  wire                          rst_n,
  input  igr_pkg::cdi_beat_t           beat0,
  input  igr_pkg::cdi_beat_t           beat1,
  input  wire                          ack,
  output logic                         req,
  output igr_pkg::igr_desc_t           out_desc,
  output logic [igr_pkg::CNT_W-1:0]    drop_count0,
  output logic [igr_pkg::CNT_W-1:0]    drop_count1
);

  // Receiver to merge
  logic                 desc_valid0;
  logic                 desc_valid1;
  igr_pkg::igr_desc_t   desc0;
  igr_pkg::igr_desc_t   desc1;
  logic                 take0;
  logic                 take1;

  // Port 0 receiver
  igr_port_rx u_port0 (
    .ingress_clock (ingress_clock),
    .rst_n         (rst_n),
    .beat          (beat0),
    .take          (take0),
    .desc_valid    (desc_valid0),
    .desc          (desc0),
    .drop_count    (drop_count0)
  );

  // Port 1 receiver
  igr_port_rx u_port1 (
    .ingress_clock (ingress_clock),
    .rst_n         (rst_n),
    .beat          (beat1),
    .take          (take1),
    .desc_valid    (desc_valid1),
    .desc          (desc1),
    .drop_count    (drop_count1)
  );

  // Arbitration and downstream handshake
  igr_merge u_merge (
    .ingress_clock (ingress_clock),
    .rst_n         (rst_n),
    .desc_valid0   (desc_valid0),
    .desc0         (desc0),
    .desc_valid1   (desc_valid1),
    .desc1         (desc1),
    .ack           (ack),
    .take0         (take0),
    .take1         (take1),
    .req           (req),
    .out_desc      (out_desc)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ingress testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module igr_tb -f filelist.f -o igr_sim

# Simulator status is ignored, the pass line decides
out=$(./obj_dir/igr_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== tests/igr_properties.sv ====
// ==========================================================
// Ingress handshake properties
// Concurrent checks on the downstream four-phase handshake
// and the port take pulses, bound into the ingress top
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module igr_properties (
  input wire                 ingress_clock,
  input wire                 rst_n,
  input wire                 req,
  input wire                 ack,
  input wire                 take0,
  input wire                 take1,
  input igr_pkg::igr_desc_t  out_desc
);

  // No request while the block is held in reset
  req_in_reset: assert property (@(posedge ingress_clock) !rst_n |-> !req)
    else $error("req high during reset");

  // Once raised, req waits for ack
  req_until_ack: assert property (@(posedge ingress_clock) disable iff (!rst_n)
    req && !ack |=> req)
    else $error("req dropped before ack");

  // Payload frozen from req rise until ack is back low
  desc_stable: assert property (@(posedge ingress_clock) disable iff (!rst_n)
    (req || ack) |=> $stable(out_desc))
    else $error("out_desc changed during handshake");

  // Return to zero completes before the next request
  no_req_rise_on_ack: assert property (@(posedge ingress_clock) disable iff (!rst_n)
    $rose(req) |-> !ack)
    else $error("req rose while ack high");

  // One grant at a time
  one_take: assert property (@(posedge ingress_clock) disable iff (!rst_n)
    !(take0 && take1))
    else $error("take0 and take1 high together");

endmodule

bind igr_top igr_properties u_props (
  .ingress_clock (ingress_clock),
  .rst_n         (rst_n),
  .req           (req),
  .ack           (ack),
  .take0         (take0),
  .take1         (take1),
  .out_desc      (out_desc)
);

`default_nettype wire

// ==== tests/igr_tb.sv ====
// ==========================================================
// Ingress front end testbench
// Random frame stimulus on both ports, a reference model of
// the frame and slot rules, a downstream ack responder
// and a per-test report
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module igr_tb;

  logic                       ingress_clock;
  logic                       rst_n;
  logic                       ack;
  igr_pkg::cdi_beat_t         beat0;
  igr_pkg::cdi_beat_t         beat1;
  logic                       req;
  igr_pkg::igr_desc_t         out_desc;
  logic [igr_pkg::CNT_W-1:0]  drop_count0;
  logic [igr_pkg::CNT_W-1:0]  drop_count1;

  // Responder controls
  logic hold_ack;
  logic fast_ack;

  // Reference model state, per port
  logic                       in_frame [2];
  logic                       cur_err [2];
  int                         cur_len [2];
  logic [igr_pkg::DATA_W-1:0] cur_head [2];
  logic [igr_pkg::DATA_W-1:0] cur_csum [2];
  logic                       d1_v [2];
  logic                       d2_v [2];
  igr_pkg::igr_desc_t         d1_desc [2];
  igr_pkg::igr_desc_t         d2_desc [2];
  logic                       slot_full [2];
  int                         model_drop [2];
  igr_pkg::igr_desc_t         exp_q [2][$];
  int                         port_log [$];
  logic                       req_q;
  int                         checked;
  int                         model_errors;

  int   chk_errors;
  logic timed_out;

  igr_top dut0 (
    .ingress_clock (ingress_clock),
    .rst_n         (rst_n),
    .beat0         (beat0),
    .beat1         (beat1),
    .ack           (ack),
    .req           (req),
    .out_desc      (out_desc),
    .drop_count0   (drop_count0),
    .drop_count1   (drop_count1)
  );

  // 40 ns clock
  initial begin
    ingress_clock = 1'b0;
    forever #20 ingress_clock = ~ingress_clock;
  end

  // ==========================================================
  // Reference model
  // ==========================================================

  // Sampled at the edge, so it sees the values the DUT samples
  always @(posedge ingress_clock) begin : ref_model
    igr_pkg::cdi_beat_t b;
    igr_pkg::igr_desc_t want;
    logic               rose;
    logic               done;
    logic [1:0]         took;
    int                 p;
    if (!rst_n) begin
      for (p = 0; p < 2; p++) begin
        in_frame[p]   = 1'b0;
        slot_full[p]  = 1'b0;
        d1_v[p]       = 1'b0;
        d2_v[p]       = 1'b0;
        model_drop[p] = 0;
      end
      req_q        = 1'b0;
      checked      = 0;
      model_errors = 0;
    end else begin
      // req rising now means take was issued in the last cycle
      rose = req && !req_q;
      took = 2'b00;
      if (rose) begin
        p = int'(out_desc.port);
        took[p] = 1'b1;
        port_log.push_back(p);
        if (exp_q[p].size() == 0) begin
          $display("Unexpected descriptor from port %0d at %0t", p, $time);
          model_errors++;
        end else begin
          want = exp_q[p].pop_front();
          assert (out_desc == want) else begin
            $display("[ERROR] %0t port %0d descriptor %h, expected %h",
                     $time, p, out_desc, want);
            model_errors++;
          end
          checked++;
        end
      end
      for (p = 0; p < 2; p++) begin
        // Slot decision for the frame that finished two edges ago
        if (d2_v[p]) begin
          if (!slot_full[p] || took[p]) begin
            slot_full[p] = 1'b1;
            exp_q[p].push_back(d2_desc[p]);
          end else begin
            model_drop[p]++;
          end
        end else if (took[p]) begin
          slot_full[p] = 1'b0;
        end
        d2_v[p]    = d1_v[p];
        d2_desc[p] = d1_desc[p];
        d1_v[p]    = 1'b0;
        // Frame rules on this beat
        b    = (p == 0) ? beat0 : beat1;
        done = 1'b0;
        if (b.valid && b.sop) begin
          cur_err[p]  = in_frame[p];
          cur_head[p] = b.data;
          cur_csum[p] = b.data;
          cur_len[p]  = 1;
          in_frame[p] = !b.eop;
          done        = b.eop;
        end else if (b.valid && in_frame[p]) begin
          if (cur_len[p] == 255) cur_err[p] = 1'b1;
          else cur_len[p] = cur_len[p] + 1;
          cur_csum[p] = cur_csum[p] ^ b.data;
          in_frame[p] = !b.eop;
          done        = b.eop;
        end
        if (done) begin
          d1_v[p]             = 1'b1;
          // Tagged with the port the frame arrived on
          d1_desc[p].port     = igr_pkg::PORT_W'(p);
          d1_desc[p].err      = cur_err[p];
          d1_desc[p].length   = igr_pkg::LEN_W'(cur_len[p]);
          d1_desc[p].head     = cur_head[p];
          d1_desc[p].checksum = cur_csum[p];
        end
      end
      req_q = req;
    end
  end

  // ==========================================================
  // Stimulus and responder
  // ==========================================================

  task automatic drive_beat(input int port, input igr_pkg::cdi_beat_t b);
    @(posedge ingress_clock);
    if (port == 0) beat0 <= b;
    else beat1 <= b;
  endtask

  // mid_sop > 0 restarts the frame at that word
  task automatic send_frame(input int port, input int len, input int mid_sop, input bit gaps);
    igr_pkg::cdi_beat_t b;
    int                 i;
    // Stray beat outside a frame, ignored by the port
    if (gaps && ($urandom % 4 == 0)) begin
      b.valid = 1'b1;
      b.sop   = 1'b0;
      b.eop   = 1'($urandom % 2);
      b.data  = $urandom;
      drive_beat(port, b);
    end
    for (i = 0; i < len; i++) begin
      if (gaps && ($urandom % 3 == 0)) begin
        b = '0;
        b.data = $urandom;
        drive_beat(port, b);
      end
      b.valid = 1'b1;
      b.sop   = (i == 0) || (i == mid_sop);
      b.eop   = (i == len - 1);
      b.data  = $urandom;
      drive_beat(port, b);
    end
    drive_beat(port, '0);
  endtask

  // Four-phase downstream side, one step per clock
  task automatic respond_ack();
    int delay;
    delay = int'($urandom % 6);
    forever begin
      @(posedge ingress_clock);
      if (ack) begin
        if (!req) ack <= 1'b0;
      end else if (req && !hold_ack) begin
        if (delay <= 0 || fast_ack) begin
          ack <= 1'b1;
          delay = int'($urandom % 6);
        end else begin
          delay = delay - 1;
        end
      end
    end
  endtask

  // ==========================================================
  // Checks and report
  // ==========================================================

  task automatic finish_run();
    int total;
    total = chk_errors + model_errors;
    $display("Summary: %0d descriptors checked, drops %0d/%0d, %0d errors",
             checked, model_drop[0], model_drop[1], total);
    if (total == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // Everything finished, delivered and the handshake back at rest
  task automatic wait_drain(input string what);
    int n;
    n = 0;
    @(negedge ingress_clock);
    while ((exp_q[0].size() != 0 || exp_q[1].size() != 0 || d1_v[0] || d1_v[1] ||
            d2_v[0] || d2_v[1] || req || ack) && n < 4000) begin
      @(negedge ingress_clock);
      n++;
    end
    if (n >= 4000) begin
      $display("Timeout: descriptors of %s not delivered within 4000 cycles", what);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_drops();
    assert (drop_count0 == igr_pkg::CNT_W'(model_drop[0])) else begin
      $display("[ERROR] %0t drop_count0 %0d, expected %0d", $time, drop_count0, model_drop[0]);
      chk_errors++;
    end
    assert (drop_count1 == igr_pkg::CNT_W'(model_drop[1])) else begin
      $display("[ERROR] %0t drop_count1 %0d, expected %0d", $time, drop_count1, model_drop[1]);
      chk_errors++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    check_drops();
    $display("Test %0d %s finished, %0d errors so far", num, name, chk_errors + model_errors);
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================

  initial begin : main
    int idx;
    int r;
    int first;
    int len0;
    int len1;
    int mid0;
    int mid1;
    int base;
    void'($urandom(32'h9cfc6a73));
    chk_errors = 0;
    timed_out  = 1'b0;
    rst_n      <= 1'b0;
    beat0      <= '0;
    beat1      <= '0;
    ack        <= 1'b0;
    hold_ack   <= 1'b0;
    fast_ack   <= 1'b1;
    fork
      respond_ack();
    join_none
    repeat (8) @(posedge ingress_clock);
    rst_n <= 1'b1;

    // 2: ties go to the port not served last
    // The first tie comes straight after reset, port 0 wins it
    for (r = 0; r < 2; r++) begin
      if (r == 1) begin
        // Port 0 served alone, the next tie belongs to port 1
        send_frame(0, 3, 0, 1'b0);
        wait_drain("lone frame port 0");
      end
      first = (r == 0) ? 0 : 1;
      idx   = port_log.size();
      fork
        send_frame(0, 4, 0, 1'b0);
        send_frame(1, 4, 0, 1'b0);
      join
      wait_drain("tied frames");
      assert (port_log.size() == idx + 2 && port_log[idx] == first &&
              port_log[idx + 1] == 1 - first)
      else begin
        $display("[ERROR] %0t tie round %0d not served port %0d then port %0d",
                 $time, r, first, 1 - first);
        chk_errors++;
      end
    end
    end_test(2, "round robin ties");

    // 1: single frames, prompt ack
    send_frame(0, 6, 0, 1'b0);
    wait_drain("single frame port 0");
    send_frame(1, 1, 0, 1'b0);
    wait_drain("single frame port 1");
    end_test(1, "single frames");

    // 3: restarted frame and a frame past the length limit
    fast_ack <= 1'b0;
    send_frame(0, 9, 4, 1'b0);
    send_frame(1, 300, 0, 1'b0);
    wait_drain("error frames");
    end_test(3, "error frames");

    // 4: ack held off, later frames find the slot full
    base     = model_drop[0] + model_drop[1];
    hold_ack <= 1'b1;
    fork
      send_frame(0, 4, 0, 1'b0);
      send_frame(1, 4, 0, 1'b0);
    join
    fork
      send_frame(0, 4, 0, 1'b0);
      send_frame(1, 4, 0, 1'b0);
    join
    fork
      send_frame(0, 4, 0, 1'b0);
      send_frame(1, 4, 0, 1'b0);
    join
    repeat (10) @(posedge ingress_clock);
    hold_ack <= 1'b0;
    wait_drain("back-pressure frames");
    assert (model_drop[0] + model_drop[1] >= base + 3) else begin
      $display("[ERROR] %0t back-pressure dropped %0d frames, expected at least 3",
               $time, model_drop[0] + model_drop[1] - base);
      chk_errors++;
    end
    end_test(4, "back-pressure");

    // 5: random traffic until 200 more descriptors are out
    base = checked;
    r    = 0;
    while (checked < base + 200 && r < 2000) begin
      len0 = 1 + int'($urandom % 12);
      len1 = 1 + int'($urandom % 12);
      mid0 = ($urandom % 8 == 0) ? int'($urandom % 12) : 0;
      mid1 = ($urandom % 8 == 0) ? int'($urandom % 12) : 0;
      fork
        send_frame(0, len0, mid0, 1'b1);
        send_frame(1, len1, mid1, 1'b1);
      join
      @(negedge ingress_clock);
      r++;
    end
    if (r >= 2000) begin
      $display("Timeout: random traffic did not deliver 200 descriptors in 2000 rounds");
      timed_out = 1'b1;
    end
    wait_drain("random traffic");
    end_test(5, "random traffic");

    finish_run();
  end

endmodule

`default_nettype wire
